// ==== Makefile ====
# Verilator build and run for the encoder testbench

VERILATOR ?= verilator
TOP       ?= tb_enc_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "simulation clean"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
design/enc_pkg.sv
design/enc_cnt.sv
design/enc_ctrl.sv
design/enc_parity_acc.sv
design/enc_out_buf.sv
design/enc_top.sv
tb/tb_enc_top.sv

// ==== design/enc_cnt.sv ====
// input and output word counters with last-word flags
`timescale 1ns/100ps

module enc_cnt import enc_pkg::*; (
  input  logic  iclk,
  input  logic  rst_n,
  input  logic  clkena,
  input  logic  clear,     // drop the frame, both counters to zero
  input  logic  in_step,   // one data word accepted
  input  logic  out_step,  // one coded word sent
  output widx_t in_idx,
  output logic  in_last,
  output widx_t out_idx,
  output logic  out_last
);

  //------------------------------------------------------------
  // last flags
  //------------------------------------------------------------

  assign in_last  = (in_idx  == widx_t'(KB - 1));     // eop slot
  assign out_last = (out_idx == widx_t'(N_OUT - 1));  // final word on the output

  //------------------------------------------------------------
  // counters, wrap on their own last word
  //------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      in_idx  <= '0;
      out_idx <= '0;
    end else if (clkena) begin
      if (clear) begin
        in_idx  <= '0;
        out_idx <= '0;
      end else begin
        if (in_step)
          in_idx <= in_last ? '0 : in_idx + 1'b1;    // back to 0 after the eop word
        if (out_step)
          out_idx <= out_last ? '0 : out_idx + 1'b1; // ready for the next frame
      end
    end
  end

  // counters never run past their frame size
  a_in_lim : assert property (@(posedge iclk) disable iff (!rst_n)
    in_idx <= widx_t'(KB - 1))
    else $error("in_idx past limit: %h", in_idx);

  a_out_lim : assert property (@(posedge iclk) disable iff (!rst_n)
    out_idx <= widx_t'(N_OUT - 1))
    else $error("out_idx past limit: %h", out_idx);

endmodule

// ==== design/enc_ctrl.sv ====
// frame FSM: accept and source error decisions, commit sequencing, busy/ready/full flags
`timescale 1ns/100ps

module enc_ctrl import enc_pkg::*; (
  input  logic     iclk,
  input  logic     rst_n,
  input  logic     clkena,
  input  in_word_t in_word,
  input  logic     in_last,   // counter sits on word KB-1
  input  logic     out_last,  // counter sits on the final output word
  input  logic     req,
  output logic     clear,
  output logic     accept,
  output logic     commit,
  output logic     out_step,
  output logic     busy,
  output logic     ready,
  output logic     src_err,
  output logic     full
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        err;       // strobe rule broken in this cycle

  //------------------------------------------------------------
  // next state and word decision
  //------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    err     = 1'b0;
    accept  = 1'b0;
    case (state_q)
      IDLE : begin
        if (in_word.val) begin
          // only a sop may open a frame, eop must sit on word KB-1
          if (!in_word.sop || (in_word.eop != in_last)) begin
            err = 1'b1;
          end else begin
            accept  = 1'b1;
            state_d = in_last ? COMMIT : RECV;  // single-word frames skip RECV
          end
        end
      end
      RECV : begin
        if (in_word.val) begin
          if (in_word.sop || (in_word.eop != in_last)) begin
            err     = 1'b1;     // sop in frame, early eop or missing eop
            state_d = IDLE;     // frame is dropped
          end else begin
            accept = 1'b1;
            if (in_last)
              state_d = COMMIT;
          end
        end
      end
      COMMIT : begin
        err     = in_word.val;  // ready is low here
        state_d = FULL;
      end
      FULL : begin
        err = in_word.val;      // word while ready low, buffered frame is kept
        if (req && out_last)
          state_d = IDLE;       // eop goes out next cycle
      end
      default : state_d = IDLE;
    endcase
  end

  //------------------------------------------------------------
  // state and error pulse
  //------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      src_err <= 1'b0;
    end else if (clkena) begin
      state_q <= state_d;
      src_err <= err;           // one pulse, the cycle after the bad word
    end
  end

  assign clear    = err && (state_q == RECV);   // only a frame in reception is dropped
  assign commit   = (state_q == COMMIT);
  assign out_step = (state_q == FULL) && req;   // req outside FULL has no effect
  assign full     = (state_q == FULL);
  assign ready    = (state_q == IDLE);          // buffer is empty only in IDLE
  assign busy     = (state_q == RECV) || (state_q == COMMIT);

  // parity commit lasts a single enabled cycle
  a_commit_once : assert property (@(posedge iclk) disable iff (!rst_n)
    (commit && clkena) |=> !commit)
    else $error("commit held longer than one cycle");

  // outside a frame nothing is taken unless the core is ready
  a_accept_rdy : assert property (@(posedge iclk) disable iff (!rst_n)
    accept |-> (ready || (state_q == RECV)))
    else $error("accept with ready low, state %h", state_q);

endmodule

// ==== design/enc_out_buf.sv ====
// one-frame coded buffer: data writes, parity and tag commit, punctured readout on req
`timescale 1ns/100ps

module enc_out_buf import enc_pkg::*; (
  input  logic           iclk,
  input  logic           rst_n,
  input  logic           clkena,
  input  logic           accept,
  input  logic           commit,
  input  widx_t          in_idx,
  input  in_word_t       in_word,
  input  word_t [NP-1:0] parity,
  input  logic           out_step,
  input  widx_t          out_idx,
  input  logic           out_last,
  output out_word_t      out_word
);

  word_t mem [KB+NP];   // slots 0..KB-1 data, KB.. parity
  tag_t  frm_tag;       // tag captured with sop
  tag_t  buf_tag;       // tag of the committed frame
  widx_t rd_idx;

  logic  o_sop;
  logic  o_val;
  logic  o_eop;
  word_t o_dat;
  tag_t  o_tag;

  //------------------------------------------------------------
  // write side
  //------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (clkena) begin
      if (accept) begin
        mem[in_idx] <= in_word.dat;               // systematic part in place
        if (in_word.sop)
          frm_tag <= in_word.tag;
      end
      if (commit) begin
        for (int r = 0; r < NP; r++)
          mem[KB + r] <= parity[r];               // parity behind the data words
        buf_tag <= frm_tag;
      end
    end
  end

  //------------------------------------------------------------
  // read side
  //------------------------------------------------------------

  // skip word 0 when punctured
  assign rd_idx = out_idx + widx_t'(DO_PUNCT);

  // strobes, one cycle after the req that asked for the word
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      o_sop <= 1'b0;
      o_val <= 1'b0;
      o_eop <= 1'b0;
    end else if (clkena) begin
      o_val <= out_step;
      o_sop <= out_step && (out_idx == '0);   // first word sent
      o_eop <= out_step && out_last;
    end
  end

  always_ff @(posedge iclk) begin
    if (clkena && out_step) begin
      o_dat <= mem[rd_idx];
      o_tag <= buf_tag;                       // same tag on every word
    end
  end

  assign out_word = '{sop: o_sop, val: o_val, eop: o_eop, dat: o_dat, tag: o_tag};

  // buffer is never rewritten while it is being read
  a_no_overlap : assert property (@(posedge iclk) disable iff (!rst_n)
    !(commit && out_step))
    else $error("commit during readout, out_idx %h", out_idx);

endmodule

// ==== design/enc_parity_acc.sv ====
// parity accumulator: per-row rotate and XOR fold of the data words over the base graph
`timescale 1ns/100ps

module enc_parity_acc import enc_pkg::*; (
  input  logic            iclk,
  input  logic            rst_n,
  input  logic            clkena,
  input  logic            clear,    // frame dropped
  input  logic            accept,   // dat is a valid data word
  input  widx_t           in_idx,   // column of the base graph
  input  word_t           dat,
  output word_t [NP-1:0]  parity    // one running word per parity row
);

  shift_t [NP-1:0] sh_sel;    // shift entry of each row for this column
  word_t  [NP-1:0] contrib;   // rotated word, zero on no edge
  logic            first;     // word 0 restarts the fold

  //------------------------------------------------------------
  // base graph lookup
  //------------------------------------------------------------

  always_comb begin
    for (int r = 0; r < NP; r++) begin
      sh_sel[r] = NO_EDGE;
      for (int c = 0; c < KB; c++) begin
        if (in_idx == widx_t'(c))
          sh_sel[r] = SHIFT[r][c];
      end
    end
  end

  // rotation per row
  always_comb begin
    for (int r = 0; r < NP; r++) begin
      if (sh_sel[r] == NO_EDGE)
        contrib[r] = '0;                 // column not connected to this row
      else
        contrib[r] = rotl(dat, sh_sel[r]);
    end
  end

  assign first = (in_idx == '0);

  //------------------------------------------------------------
  // fold registers
  //------------------------------------------------------------

  // rows start from zero on word 0, so the result is ready the cycle after eop
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      parity <= '0;
    end else if (clkena) begin
      if (clear) begin
        parity <= '0;
      end else if (accept) begin
        for (int r = 0; r < NP; r++)
          parity[r] <= (first ? '0 : parity[r]) ^ contrib[r];
      end
    end
  end

endmodule

// ==== design/enc_pkg.sv ====
// encoder package: code sizes, base graph shift table, puncture flag, word types, states, strobe structs
package enc_pkg;

  //------------------------------------------------------------
  // code dimensions
  //------------------------------------------------------------

  localparam int Z        = 8;     // lifting size, one word is one Z-bit block
  localparam int KB       = 4;     // data words per frame
  localparam int NP       = 2;     // parity words per frame
  localparam bit DO_PUNCT = 1'b1;  // word 0 is not sent
  localparam int N_OUT    = KB + NP - int'(DO_PUNCT);  // words on the output per frame
  localparam int TAG_W    = 4;

  localparam int WIDX_W   = $clog2(KB + NP);  // covers data and parity slots
  localparam int SHIFT_W  = $clog2(Z) + 1;    // rotation 0..Z-1 plus a spare code

  //------------------------------------------------------------
  // basic types
  //------------------------------------------------------------

  typedef logic [Z-1:0]       word_t;   // one lifting block
  typedef logic [TAG_W-1:0]   tag_t;    // frame tag
  typedef logic [WIDX_W-1:0]  widx_t;   // word index inside the coded frame
  typedef logic [SHIFT_W-1:0] shift_t;  // base graph entry

  // spare code, the column has no edge in that row
  localparam shift_t NO_EDGE = '1;

  // base graph, NP rows by KB columns, entry = left rotation of the data word
  localparam shift_t SHIFT [NP][KB] = '{
    '{4'd1, 4'd3, NO_EDGE, 4'd6},   // parity row 0
    '{4'd0, NO_EDGE, 4'd5, 4'd2}    // parity row 1
  };

  // frame control states
  typedef enum logic [1:0] {
    IDLE,    // buffer empty, waiting for sop
    RECV,    // taking data words
    COMMIT,  // parity rows complete, move them to the buffer
    FULL     // coded frame waits for req
  } ctrl_state_t;

  // source side strobes
  typedef struct packed {
    logic  sop;
    logic  val;
    logic  eop;
    word_t dat;
    tag_t  tag;
  } in_word_t;

  // sink side strobes
  typedef struct packed {
    logic  sop;
    logic  val;
    logic  eop;
    word_t dat;
    tag_t  tag;
  } out_word_t;

  // cyclic left rotation of a lifting block
  function automatic word_t rotl(word_t w, shift_t sh);
    logic [2*Z-1:0] dbl;
    dbl = {w, w} << sh;        // upper half now holds the rotated word
    return dbl[2*Z-1 -: Z];
  endfunction

endpackage

// ==== design/enc_top.sv ====
// encoder top: FSM, counters, parity accumulator and output buffer wired together
`timescale 1ns/100ps

module enc_top import enc_pkg::*; (
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      clkena,
  input  in_word_t  in_word,
  input  logic      req,
  output logic      busy,
  output logic      ready,
  output logic      src_err,
  output logic      full,
  output out_word_t out_word
);

  //------------------------------------------------------------
  // internal control
  //------------------------------------------------------------

  logic           clear;      // drop frame in reception
  logic           accept;     // data word taken
  logic           commit;     // parity into buffer
  logic           out_step;   // one word read out
  widx_t          in_idx;
  logic           in_last;
  widx_t          out_idx;
  logic           out_last;
  word_t [NP-1:0] parity;

  enc_ctrl u_ctrl (
    .iclk     ( iclk     ),
    .rst_n    ( rst_n    ),
    .clkena   ( clkena   ),
    .in_word  ( in_word  ),
    .in_last  ( in_last  ),
    .out_last ( out_last ),
    .req      ( req      ),
    .clear    ( clear    ),
    .accept   ( accept   ),
    .commit   ( commit   ),
    .out_step ( out_step ),
    .busy     ( busy     ),
    .ready    ( ready    ),
    .src_err  ( src_err  ),
    .full     ( full     )
  );

  enc_cnt u_cnt (
    .iclk     ( iclk     ),
    .rst_n    ( rst_n    ),
    .clkena   ( clkena   ),
    .clear    ( clear    ),
    .in_step  ( accept   ),
    .out_step ( out_step ),
    .in_idx   ( in_idx   ),
    .in_last  ( in_last  ),
    .out_idx  ( out_idx  ),
    .out_last ( out_last )
  );

  //------------------------------------------------------------
  // datapath
  //------------------------------------------------------------

  enc_parity_acc u_acc (
    .iclk     ( iclk        ),
    .rst_n    ( rst_n       ),
    .clkena   ( clkena      ),
    .clear    ( clear       ),
    .accept   ( accept      ),
    .in_idx   ( in_idx      ),
    .dat      ( in_word.dat ),
    .parity   ( parity      )
  );

  enc_out_buf u_buf (
    .iclk     ( iclk     ),
    .rst_n    ( rst_n    ),
    .clkena   ( clkena   ),
    .accept   ( accept   ),
    .commit   ( commit   ),
    .in_idx   ( in_idx   ),
    .in_word  ( in_word  ),
    .parity   ( parity   ),
    .out_step ( out_step ),
    .out_idx  ( out_idx  ),
    .out_last ( out_last ),
    .out_word ( out_word )
  );

endmodule

// ==== tb/tb_enc_top.sv ====
// enc_top testbench with clock, reset, LFSR stimulus, reference model, checks, watchdog and report
`timescale 1ns/100ps

module tb_enc_top import enc_pkg::*; ();

  localparam int CLK_NS    = 4;
  localparam int N_FRAMES  = 24;                      // random good frames in the first run
  localparam int FRAME_CYC = 8 * (KB + N_OUT + 2);    // worst frame with clkena and req gaps
  localparam int WD_NS     = (N_FRAMES + 10) * FRAME_CYC * CLK_NS;

  logic      iclk;
  logic      rst_n;
  logic      clkena;
  in_word_t  in_word;
  logic      req;
  logic      busy;
  logic      ready;
  logic      src_err;
  logic      full;
  out_word_t out_word;

  logic        sop_ok;           // driven word is a sop the core must take
  logic        eop_ok;           // driven word closes a good frame
  logic [15:0] gap_lfsr = 16'd12;
  logic [15:0] dat_lfsr = 16'd12;
  logic        ena_bit;          // first of the two bits behind clkena
  out_word_t   exp_q[$];         // expected coded words in output order
  out_word_t   exp_head;
  logic        exp_valid;
  int          eop_age;          // enabled cycles since the good eop was taken
  int          src_cnt;
  int          exp_src;
  int          err_dat;
  int          err_tag;
  int          err_frm;
  int          err_tim;
  int          err_rst;
  int          err_src;

  enc_top u_dut (
    .iclk     ( iclk     ),
    .rst_n    ( rst_n    ),
    .clkena   ( clkena   ),
    .in_word  ( in_word  ),
    .req      ( req      ),
    .busy     ( busy     ),
    .ready    ( ready    ),
    .src_err  ( src_err  ),
    .full     ( full     ),
    .out_word ( out_word )
  );

  initial begin
    iclk = 1'b0;
    forever #(CLK_NS / 2) iclk = ~iclk;
  end

  //------------------------------------------------------------
  // random source and reference model
  //------------------------------------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1 feeding back into bit 0
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      dat_lfsr = lfsr_step(dat_lfsr);
      v = {v[14:0], dat_lfsr[0]};
    end
  endtask

  function automatic word_t rot_left(input word_t w, input int s);
    word_t r;
    for (int i = 0; i < Z; i++)
      r[(i + s) % Z] = w[i];         // bit i moves up by s
    return r;
  endfunction

  // coded frame from the base graph without the punctured words
  task automatic push_expected(input word_t [KB-1:0] d, input tag_t t);
    word_t cw [KB+NP];
    int    first;
    first = DO_PUNCT ? 1 : 0;
    for (int c = 0; c < KB; c++)
      cw[c] = d[c];
    for (int r = 0; r < NP; r++) begin
      cw[KB + r] = '0;
      for (int c = 0; c < KB; c++)
        if (SHIFT[r][c] != NO_EDGE)
          cw[KB + r] ^= rot_left(d[c], int'(SHIFT[r][c]));
    end
    for (int i = first; i < KB + NP; i++)
      exp_q.push_back('{sop: (i == first), val: 1'b1, eop: (i == KB + NP - 1),
                        dat: cw[i], tag: t});
  endtask

  //------------------------------------------------------------
  // drivers
  //------------------------------------------------------------

  // clkena low about one cycle in four and req high about half the time
  initial begin
    clkena = 1'b1;
    req    = 1'b0;
    forever begin
      @(posedge iclk);
      gap_lfsr = lfsr_step(gap_lfsr);
      ena_bit  = gap_lfsr[0];
      gap_lfsr = lfsr_step(gap_lfsr);
      clkena  <= ena_bit | gap_lfsr[0];
      gap_lfsr = lfsr_step(gap_lfsr);
      req     <= gap_lfsr[0];
    end
  end

  // word holds until an enabled edge has taken it
  task automatic send_word(input logic s, input logic e, input word_t d, input tag_t t,
                           input logic so, input logic eo);
    in_word <= '{sop: s, val: 1'b1, eop: e, dat: d, tag: t};
    sop_ok  <= so;
    eop_ok  <= eo;
    do @(posedge iclk); while (!clkena);
  endtask

  task automatic idle_in();
    in_word <= '0;
    sop_ok  <= 1'b0;
    eop_ok  <= 1'b0;
  endtask

  task automatic wait_ready();
    do @(posedge iclk); while (!ready);
  endtask

  task automatic good_frame();
    word_t [KB-1:0] d;
    tag_t           t;
    logic [15:0]    v;
    for (int c = 0; c < KB; c++) begin
      take_bits(Z, v);
      d[c] = v[Z-1:0];
    end
    take_bits(TAG_W, v);
    t = v[TAG_W-1:0];
    push_expected(d, t);
    wait_ready();
    for (int c = 0; c < KB; c++)
      send_word(c == 0, c == KB - 1, d[c], t, c == 0, c == KB - 1);
    idle_in();
  endtask

  //------------------------------------------------------------
  // expected word tracking
  //------------------------------------------------------------

  always @(posedge iclk) begin
    if (rst_n && clkena && out_word.val && exp_q.size() != 0)
      void'(exp_q.pop_front());      // sink takes a word on every enabled edge
    exp_valid <= (exp_q.size() != 0);
    exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  always @(posedge iclk) begin
    if (!rst_n || full)
      eop_age <= 0;
    else if (clkena && in_word.val && eop_ok)
      eop_age <= 1;
    else if (clkena && eop_age != 0)
      eop_age <= eop_age + 1;
    if (rst_n && clkena && src_err)
      src_cnt <= src_cnt + 1;        // a held pulse counts once
  end

  //------------------------------------------------------------
  // checking assertions
  //------------------------------------------------------------

  a_no_extra : assert property (@(posedge iclk) disable iff (!rst_n)
    (clkena && out_word.val) |-> exp_valid)
    else begin
      err_frm++;
      $display("output word sent while no coded word was expected");
    end

  a_dat : assert property (@(posedge iclk) disable iff (!rst_n)
    (clkena && out_word.val && exp_valid) |-> (out_word.dat == exp_head.dat))
    else begin
      err_dat++;
      $display("error out_word.dat got %h exp %h",
               $sampled(out_word.dat), $sampled(exp_head.dat));
    end

  a_tag : assert property (@(posedge iclk) disable iff (!rst_n)
    (clkena && out_word.val && exp_valid) |-> (out_word.tag == exp_head.tag))
    else begin
      err_tag++;
      $display("error out_word.tag got %h exp %h",
               $sampled(out_word.tag), $sampled(exp_head.tag));
    end

  a_sop_eop : assert property (@(posedge iclk) disable iff (!rst_n)
    (clkena && out_word.val && exp_valid) |->
      ({out_word.sop, out_word.eop} == {exp_head.sop, exp_head.eop}))
    else begin
      err_frm++;
      $display("error out_word.sop/eop got %h exp %h", $sampled({out_word.sop, out_word.eop}),
               $sampled({exp_head.sop, exp_head.eop}));
    end

  a_full_rise : assert property (@(posedge iclk) disable iff (!rst_n)
    $rose(full) |-> (eop_age == 2))
    else begin
      err_tim++;
      $display("full rose %0d enabled cycles after eop", $sampled(eop_age));
    end

  a_full_fall : assert property (@(posedge iclk) disable iff (!rst_n)
    $fell(full) |-> (out_word.val && out_word.eop))
    else begin
      err_tim++;
      $display("full fell without the output eop");
    end

  a_rdy_full : assert property (@(posedge iclk) disable iff (!rst_n)
    !(ready && full) && !(busy && (ready || full)))
    else begin
      err_tim++;
      $display("busy, ready and full overlap");
    end

  a_busy_rise : assert property (@(posedge iclk) disable iff (!rst_n)
    (clkena && in_word.val && sop_ok) |=> busy)
    else begin
      err_tim++;
      $display("busy stayed low after an accepted sop");
    end

  // busy ends only when full rises or the frame is dropped
  a_busy_hold : assert property (@(posedge iclk) disable iff (!rst_n)
    busy |=> (busy || full || src_err))
    else begin
      err_tim++;
      $display("busy fell before full rose");
    end

  //------------------------------------------------------------
  // sequence
  //------------------------------------------------------------

  initial begin : watchdog
    #(WD_NS);
    $display("watchdog expired before all frames were read out");
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    in_word = '0;
    rst_n   = 1'b0;
    sop_ok  = 1'b0;
    eop_ok  = 1'b0;
    repeat (3) @(posedge iclk);
    assert (ready && !busy && !full && !src_err && !out_word.val && !out_word.sop &&
            !out_word.eop)
      else begin
        err_rst++;
        $display("flags not in their reset state");
      end
    rst_n <= 1'b1;

    for (int f = 0; f < N_FRAMES; f++)
      good_frame();

    // val without sop
    wait_ready();
    send_word(1'b0, 1'b0, 8'h5a, 4'h3, 1'b0, 1'b0);
    exp_src++;
    idle_in();
    // eop on word 1
    wait_ready();
    send_word(1'b1, 1'b0, 8'h11, 4'h6, 1'b1, 1'b0);
    send_word(1'b0, 1'b1, 8'h22, 4'h6, 1'b0, 1'b0);
    exp_src++;
    idle_in();
    // no eop on word KB-1
    wait_ready();
    for (int c = 0; c < KB; c++)
      send_word(c == 0, 1'b0, word_t'(8'hc0 + c), 4'h9, c == 0, 1'b0);
    exp_src++;
    idle_in();
    // sop right after a good eop while the core is not ready
    good_frame();
    send_word(1'b1, 1'b0, 8'ha5, 4'hf, 1'b0, 1'b0);
    exp_src++;
    idle_in();

    for (int f = 0; f < 4; f++)
      good_frame();

    do @(posedge iclk); while (exp_q.size() != 0 || !ready);
    repeat (8) @(posedge iclk);
    assert (src_cnt == exp_src)
      else begin
        err_src++;
        $display("error src_err count got %h exp %h", src_cnt, exp_src);
      end

    $display("errors: dat %0d tag %0d framing %0d timing %0d reset %0d src_err %0d",
             err_dat, err_tag, err_frm, err_tim, err_rst, err_src);
    if (err_dat + err_tag + err_frm + err_tim + err_rst + err_src == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule
